// ==== testbench/sdram_vectors.txt ====
# name op(W/R) addr(hex {bank,row,col}) data(hex, expected for R) tag(hex)
# One request per line, issued in file order
wr_b0 W 000010 1234 01
wr_b1 W 400020 abcd 02
wr_b2 W 812345 5a5a 03
wr_b3 W ffffff c3c3 04
rd_b0 R 000010 1234 05
rd_b1 R 400020 abcd 06
rd_b2 R 812345 5a5a 07
rd_b3 R ffffff c3c3 08
ow_b0 W 000010 beef 09
rd_ow R 000010 beef 0a
rd_zero R 2003ff 0000 0b
wr_row W 00a010 7777 0c
rd_row R 00a010 7777 0d
rd_b0_again R 000010 beef 0e

// ==== list.f ====
+incdir+include
hw/sdram_pkg.sv
hw/sdram_cmd_sched.sv
hw/sdram_io.sv
hw/sdram_read_return.sv
hw/sdram_ctrl_top.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/sdram_ctrl_props.sv
testbench/sdram_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module sdram_ctrl_tb -Mdir obj_dir > compile.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile step failed, see compile.log"
    exit 1
fi

./obj_dir/Vsdram_ctrl_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0

// ==== testbench/sdram_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_ctrl_tb
    import sdram_pkg::*;
();

logic        CLK;
logic        rst_n;
logic        req_valid;
logic        req_write;
host_addr_t  req_addr;
sdram_data_t req_wdata;
sdram_tag_t  req_tag;
logic        credit_return;
logic        rd_valid;
sdram_tag_t  rd_tag;
sdram_data_t rd_data;
sdram_row_t  DRAM_ADDR;
sdram_bank_t DRAM_BA;
logic [1:0]  DRAM_DQM;
logic        DRAM_CKE;
logic        DRAM_CS_N;
logic        DRAM_RAS_N;
logic        DRAM_CAS_N;
logic        DRAM_WE_N;
wire         DRAM_CLK;
wire [`SDRAM_DATA_W-1:0] DRAM_DQ;

tb_clock clk_gen (.CLK(CLK), .rst_n(rst_n));

sdram_ctrl_top dut0 (.*);

sdram_model mem0 (
    .CLK(DRAM_CLK), .rst_n(rst_n), .DRAM_ADDR(DRAM_ADDR), .DRAM_BA(DRAM_BA),
    .DRAM_CS_N(DRAM_CS_N), .DRAM_RAS_N(DRAM_RAS_N), .DRAM_CAS_N(DRAM_CAS_N),
    .DRAM_WE_N(DRAM_WE_N), .DRAM_DQ(DRAM_DQ)
);

// Request list and scoreboard
logic        rq_write [$];
host_addr_t  rq_addr  [$];
sdram_data_t rq_data  [$];
sdram_tag_t  rq_tag   [$];
string       rq_name  [$];
sdram_tag_t  exp_tag  [$];
sdram_data_t exp_data [$];
string       exp_name [$];
sdram_data_t shadow [host_addr_t];

int          n_req = 0;
int          n_reads = 0;
int          rd_count = 0;
int          cr_count = 0;
int          credits;
int          cycle = 0;
int          init_seen = 0;
int          ref_total = 0;
int          last_ref = 0;
logic [31:0] lfsr = 32'h1bc5_123e;

task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
    if (expected !== actual) begin
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    end
endtask

// Galois LFSR with x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v    = {v[30:0], lfsr[0]};
    end
endtask

task automatic add_req(input string name, input logic wr, input host_addr_t a,
                       input sdram_data_t d, input sdram_tag_t t);
    rq_name.push_back(name);
    rq_write.push_back(wr);
    rq_addr.push_back(a);
    rq_data.push_back(d);
    rq_tag.push_back(t);
endtask

// ************************************************************
// Vector file and random phase
// ************************************************************
task automatic load_requests();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       opstr;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] t;
    logic [31:0] ra;
    logic [31:0] rdat;
    host_addr_t  waddr [32];
    fd = $fopen("testbench/sdram_vectors.txt", "r");
    if (fd == 0) begin
        $display("cannot open the vector file");
        $display("Regression failed");
        $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() == 0 || line[0] == "#")
            continue;
        n = $sscanf(line, "%s %s %h %h %h", name, opstr, a, d, t);
        if (n == 5)
            add_req(name, opstr == "W", host_addr_t'(a), sdram_data_t'(d), sdram_tag_t'(t));
    end
    $fclose(fd);
    for (int i = 0; i < 32; i++) begin
        take_bits(`SDRAM_HOST_ADDR_W, ra);
        take_bits(`SDRAM_DATA_W, rdat);
        waddr[i] = host_addr_t'(ra);
        add_req($sformatf("rnd_wr%0d", i), 1'b1, waddr[i], sdram_data_t'(rdat),
                sdram_tag_t'(i));
    end
    for (int i = 0; i < 32; i++)
        add_req($sformatf("rnd_rd%0d", i), 1'b0, waddr[i], '0, sdram_tag_t'(8'h80 + i));
    n_req = rq_name.size();
endtask

// Waits for a credit, then drives one request
task automatic send_req(input int k);
    int avail;
    forever begin
        @(posedge CLK);
        avail = credits - int'(req_valid) + int'(credit_return);
        if (avail > 0)
            break;
        req_valid <= 1'b0;
    end
    req_valid <= 1'b1;
    req_write <= rq_write[k];
    req_addr  <= rq_addr[k];
    req_wdata <= rq_data[k];
    req_tag   <= rq_tag[k];
    if (rq_write[k]) begin
        shadow[rq_addr[k]] = rq_data[k];
    end else begin
        n_reads++;
        exp_name.push_back(rq_name[k]);
        exp_tag.push_back(rq_tag[k]);
        // Random reads expect the last value written there
        if (rq_name[k].substr(0, 3) == "rnd_")
            exp_data.push_back(shadow.exists(rq_addr[k]) ? shadow[rq_addr[k]] : '0);
        else
            exp_data.push_back(rq_data[k]);
    end
endtask

// ************************************************************
// Monitors
// ************************************************************
always @(posedge CLK) begin
    if (!rst_n) begin
        credits <= `SDRAM_REQ_DEPTH;
    end else begin
        credits <= credits - int'(req_valid) + int'(credit_return);
        if (credit_return)
            cr_count++;
        check("credit_bound", 1, (credits >= 0) && (credits <= `SDRAM_REQ_DEPTH));
    end
end

always @(posedge CLK) begin
    logic [2:0] cmd;
    cmd = {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N};
    cycle++;
    if (rst_n) begin
        check("cke_high", 1, DRAM_CKE);
        check("cs_low", 0, DRAM_CS_N);
        check("dqm_zero", 0, DRAM_DQM);
    end
    if (rst_n && !DRAM_CS_N && cmd != 3'b111) begin
        if (init_seen < 4) begin
            case (init_seen)
                0: begin
                    check("init_pre", 3'b010, cmd);
                    check("init_pre_a10", 1, DRAM_ADDR[10]);
                end
                1, 2: check("init_ref", 3'b001, cmd);
                default: begin
                    check("init_mrs", 3'b000, cmd);
                    check("mrs_cas", `SDRAM_CAS, DRAM_ADDR[6:4]);
                    check("mrs_bl1", 0, DRAM_ADDR[2:0]);
                end
            endcase
            init_seen++;
        end
        if (cmd == 3'b001) begin
            if (ref_total > 0)
                check("refresh_gap", 1, (cycle - last_ref) <= `SDRAM_T_REF + 40);
            ref_total++;
            last_ref = cycle;
        end
    end
end

always @(posedge CLK) begin
    if (rst_n && rd_valid) begin
        if (exp_tag.size() == 0) begin
            $display("read result arrived with no read pending");
            $display("Regression failed");
            $fatal(1, "unexpected read result");
        end
        check({exp_name[0], "_tag"}, exp_tag[0], rd_tag);
        check({exp_name[0], "_data"}, exp_data[0], rd_data);
        void'(exp_name.pop_front());
        void'(exp_tag.pop_front());
        void'(exp_data.pop_front());
        rd_count++;
    end
end

// Watchdog sized from the request count
initial begin
    wait (n_req > 0);
    repeat (n_req * 40 + `SDRAM_T_INIT + 200) @(posedge CLK);
    $display("run timed out before all requests completed");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
end

// ************************************************************
// Main sequence
// ************************************************************
initial begin
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_tag   = '0;
    load_requests();
    wait (rst_n);
    for (int k = 0; k < n_req; k++)
        send_req(k);
    @(posedge CLK);
    req_valid <= 1'b0;
    while (exp_tag.size() != 0 || credits != `SDRAM_REQ_DEPTH)
        @(posedge CLK);
    repeat (2) @(posedge CLK);
    check("read_count", n_reads, rd_count);
    check("credit_returns", n_req, cr_count);
    check("init_commands", 4, init_seen);
    check("periodic_refresh", 1, ref_total > 2);
    $display("Regression passed");
    $finish;
end

endmodule

`default_nettype wire

// ==== testbench/sdram_ctrl_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_ctrl_props (
    input logic CLK,
    input logic rst_n,
    input logic req_valid,
    input logic credit_return,
    input logic rd_valid,
    input logic DRAM_CS_N,
    input logic DRAM_RAS_N,
    input logic DRAM_CAS_N,
    input logic DRAM_WE_N
);

logic [2:0] cmd;
logic       is_act;
logic       is_pre;
logic       is_rw;
logic [7:0] since_act;
logic [7:0] since_pre;
int         outstanding;

assign cmd    = {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N};
assign is_act = !DRAM_CS_N && (cmd == 3'b011);
assign is_pre = !DRAM_CS_N && (cmd == 3'b010);
assign is_rw  = !DRAM_CS_N && ((cmd == 3'b100) || (cmd == 3'b101));

// Cycles since the last ACT and PRE, saturating
always_ff @(posedge CLK) begin
    if (!rst_n) begin
        since_act   <= 8'hff;
        since_pre   <= 8'hff;
        outstanding <= 0;
    end else begin
        if (is_act)
            since_act <= 8'd1;
        else if (since_act != 8'hff)
            since_act <= since_act + 8'd1;
        if (is_pre)
            since_pre <= 8'd1;
        else if (since_pre != 8'hff)
            since_pre <= since_pre + 8'd1;
        outstanding <= outstanding + int'(req_valid) - int'(credit_return);
    end
end

a_rcd: assert property (@(posedge CLK) disable iff (!rst_n)
    is_rw |-> since_act >= `SDRAM_T_RCD) else $error("READ or WRITE inside tRCD");

a_rp: assert property (@(posedge CLK) disable iff (!rst_n)
    is_act |-> since_pre >= `SDRAM_T_RP) else $error("ACT inside tRP");

a_credit: assert property (@(posedge CLK) disable iff (!rst_n)
    outstanding <= `SDRAM_REQ_DEPTH) else $error("Host holds too many credits");

a_rst_rd: assert property (@(posedge CLK)
    !rst_n |=> !rd_valid) else $error("rd_valid high in reset");

endmodule

bind sdram_ctrl_top sdram_ctrl_props props0 (.*);

`default_nettype wire

// ==== testbench/sdram_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_model
    import sdram_pkg::*;
(
    input  wire                     CLK,
    input  wire                     rst_n,
    input  sdram_row_t              DRAM_ADDR,
    input  sdram_bank_t             DRAM_BA,
    input  wire                     DRAM_CS_N,
    input  wire                     DRAM_RAS_N,
    input  wire                     DRAM_CAS_N,
    input  wire                     DRAM_WE_N,
    inout  wire [`SDRAM_DATA_W-1:0] DRAM_DQ
);

localparam int CAS = `SDRAM_CAS;

sdram_data_t    mem [host_addr_t];   // Unwritten words read as zero
sdram_row_t     open_row [4];
logic [CAS-1:0] rd_v;
sdram_data_t    rd_d [CAS];
logic [2:0]     cmd;
host_addr_t     word_addr;

assign cmd       = {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N};
assign word_addr = {DRAM_BA, open_row[DRAM_BA], DRAM_ADDR[`SDRAM_COL_W-1:0]};

always @(posedge CLK) begin
    if (!rst_n) begin
        rd_v <= '0;
    end else begin
        rd_v <= {rd_v[CAS-2:0], 1'b0};
        for (int i = 1; i < CAS; i++)
            rd_d[i] <= rd_d[i-1];
        if (!DRAM_CS_N) begin
            case (cmd)
                3'b011: open_row[DRAM_BA] <= DRAM_ADDR;       // ACT
                3'b100: mem[word_addr] = DRAM_DQ;             // WRITE
                3'b101: begin                                 // READ
                    rd_v[0]  <= 1'b1;
                    rd_d[0]  <= mem.exists(word_addr) ? mem[word_addr] : '0;
                end
                default: ;
            endcase
        end
    end
end

// Data valid at the edge CAS cycles after the READ edge
assign DRAM_DQ = rd_v[CAS-1] ? rd_d[CAS-1] : 'z;

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic rst_n
);

initial begin
    CLK   = 1'b0;
    rst_n = 1'b0;
    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
end

always #4 CLK = ~CLK;     // 8 ns period

endmodule

`default_nettype wire

// ==== hw/sdram_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_ctrl_top
    import sdram_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst_n,
    // Host requests
    input  logic                    req_valid,
    input  logic                    req_write,
    input  host_addr_t              req_addr,
    input  sdram_data_t             req_wdata,
    input  sdram_tag_t              req_tag,
    output logic                    credit_return,
    // Read results
    output logic                    rd_valid,
    output sdram_tag_t              rd_tag,
    output sdram_data_t             rd_data,
    // SDRAM pins
    output sdram_row_t              DRAM_ADDR,
    output sdram_bank_t             DRAM_BA,
    output logic [1:0]              DRAM_DQM,
    output logic                    DRAM_CKE,
    output logic                    DRAM_CS_N,
    output logic                    DRAM_RAS_N,
    output logic                    DRAM_CAS_N,
    output logic                    DRAM_WE_N,
    output wire                     DRAM_CLK,
    inout  wire [`SDRAM_DATA_W-1:0] DRAM_DQ
);

sdram_op_t   sched_op;
sdram_bank_t sched_bank;
sdram_row_t  sched_row;
sdram_data_t sched_wdata;
logic        rd_issue;
sdram_tag_t  rd_issue_tag;
sdram_data_t dq_capture;

sdram_cmd_sched u_sched (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_tag       (req_tag),
    .credit_return (credit_return),
    .op            (sched_op),
    .bank          (sched_bank),
    .row_addr      (sched_row),
    .wdata         (sched_wdata),
    .rd_issue      (rd_issue),
    .rd_issue_tag  (rd_issue_tag)
);

sdram_io u_io (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .op         (sched_op),
    .bank       (sched_bank),
    .row_addr   (sched_row),
    .wdata      (sched_wdata),
    .dq_capture (dq_capture),
    .DRAM_ADDR  (DRAM_ADDR),
    .DRAM_BA    (DRAM_BA),
    .DRAM_DQM   (DRAM_DQM),
    .DRAM_CKE   (DRAM_CKE),
    .DRAM_CS_N  (DRAM_CS_N),
    .DRAM_RAS_N (DRAM_RAS_N),
    .DRAM_CAS_N (DRAM_CAS_N),
    .DRAM_WE_N  (DRAM_WE_N),
    .DRAM_CLK   (DRAM_CLK),
    .DRAM_DQ    (DRAM_DQ)
);

sdram_read_return u_ret (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .rd_issue     (rd_issue),
    .rd_issue_tag (rd_issue_tag),
    .dq_capture   (dq_capture),
    .rd_valid     (rd_valid),
    .rd_tag       (rd_tag),
    .rd_data      (rd_data)
);

endmodule

`default_nettype wire

// ==== hw/sdram_read_return.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_read_return
    import sdram_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        rd_issue,
    input  sdram_tag_t  rd_issue_tag,
    input  sdram_data_t dq_capture,
    output logic        rd_valid,
    output sdram_tag_t  rd_tag,
    output sdram_data_t rd_data
);

localparam int LAT = `SDRAM_READ_LATENCY;

logic [LAT-1:0] vld_pipe;
sdram_tag_t     tag_pipe [LAT];
sdram_data_t    data_q;

// One entry per cycle, so several reads can be in flight
always_ff @(posedge CLK) begin
    if (!rst_n)
        vld_pipe <= '0;
    else
        vld_pipe <= {vld_pipe[LAT-2:0], rd_issue};
end

always_ff @(posedge CLK) begin
    tag_pipe[0] <= rd_issue_tag;
    for (int i = 1; i < LAT; i++)
        tag_pipe[i] <= tag_pipe[i-1];
    data_q <= dq_capture;     // Alignment stage
end

assign rd_valid = vld_pipe[LAT-1];
assign rd_tag   = tag_pipe[LAT-1];
assign rd_data  = data_q;

endmodule

`default_nettype wire

// ==== hw/sdram_io.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_io
    import sdram_pkg::*;
(
    input  logic                     CLK,
    input  logic                     rst_n,
    input  sdram_op_t                op,
    input  sdram_bank_t              bank,
    input  sdram_row_t               row_addr,
    input  sdram_data_t              wdata,
    output sdram_data_t              dq_capture,
    output sdram_row_t               DRAM_ADDR,
    output sdram_bank_t              DRAM_BA,
    output logic [1:0]               DRAM_DQM,
    output logic                     DRAM_CKE,
    output logic                     DRAM_CS_N,
    output logic                     DRAM_RAS_N,
    output logic                     DRAM_CAS_N,
    output logic                     DRAM_WE_N,
    output wire                      DRAM_CLK,
    inout  wire [`SDRAM_DATA_W-1:0]  DRAM_DQ
);

localparam int PALL_BIT = 10;

// ************************************************************
// Command encoding
// ************************************************************
logic [2:0] cmd_nxt;     // {RAS_N, CAS_N, WE_N}
sdram_row_t addr_nxt;

always_comb begin
    cmd_nxt  = 3'b111;
    addr_nxt = row_addr;
    case (op)
        OP_REF:   cmd_nxt = 3'b001;
        OP_PRE: begin
            cmd_nxt            = 3'b010;
            addr_nxt[PALL_BIT] = 1'b1;   // All banks
        end
        OP_ACT:   cmd_nxt = 3'b011;
        OP_WRITE: cmd_nxt = 3'b100;
        OP_READ:  cmd_nxt = 3'b101;
        OP_MRS:   cmd_nxt = 3'b000;
        default:  cmd_nxt = 3'b111;
    endcase
end

// ************************************************************
// Pin registers
// ************************************************************
logic        dq_oe;
sdram_data_t dq_out;

always_ff @(posedge CLK) begin
    if (!rst_n) begin
        DRAM_CKE   <= 1'b1;
        DRAM_CS_N  <= 1'b0;
        DRAM_DQM   <= 2'b00;
        DRAM_RAS_N <= 1'b1;
        DRAM_CAS_N <= 1'b1;
        DRAM_WE_N  <= 1'b1;
        dq_oe      <= 1'b0;
    end else begin
        DRAM_CKE   <= 1'b1;
        DRAM_CS_N  <= 1'b0;
        DRAM_DQM   <= 2'b00;      // No byte masking
        {DRAM_RAS_N, DRAM_CAS_N, DRAM_WE_N} <= cmd_nxt;
        dq_oe      <= (op == OP_WRITE);
    end
end

// Address, bank and data ride along with the command
always_ff @(posedge CLK) begin
    DRAM_ADDR  <= addr_nxt;
    DRAM_BA    <= bank;
    dq_out     <= wdata;
    dq_capture <= DRAM_DQ;
end

assign DRAM_DQ  = dq_oe ? dq_out : 'z;
assign DRAM_CLK = CLK;

endmodule

`default_nettype wire

// ==== hw/sdram_cmd_sched.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_cmd_sched
    import sdram_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_write,
    input  host_addr_t  req_addr,
    input  sdram_data_t req_wdata,
    input  sdram_tag_t  req_tag,
    output logic        credit_return,
    output sdram_op_t   op,
    output sdram_bank_t bank,
    output sdram_row_t  row_addr,
    output sdram_data_t wdata,
    output logic        rd_issue,
    output sdram_tag_t  rd_issue_tag
);

localparam int PTR_W   = $clog2(`SDRAM_REQ_DEPTH);
localparam int CNT_W   = 16;
localparam int RAS_GAP = (`SDRAM_T_RAS > `SDRAM_T_RCD) ? (`SDRAM_T_RAS - `SDRAM_T_RCD) : 1;

// Burst length 1, sequential, CAS in A6..A4
localparam sdram_row_t MODE_WORD = {6'b000000, 3'(`SDRAM_CAS), 4'b0000};

sched_state_t state;

// ************************************************************
// Request queue
// ************************************************************
logic [`SDRAM_REQ_DEPTH-1:0] q_write;
host_addr_t  q_addr  [`SDRAM_REQ_DEPTH];
sdram_data_t q_wdata [`SDRAM_REQ_DEPTH];
sdram_tag_t  q_tag   [`SDRAM_REQ_DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   q_count;
host_addr_t       head_addr;

always_ff @(posedge CLK) begin
    if (req_valid) begin
        q_write[wr_ptr] <= req_write;
        q_addr[wr_ptr]  <= req_addr;
        q_wdata[wr_ptr] <= req_wdata;
        q_tag[wr_ptr]   <= req_tag;
    end
end

// Credits keep the queue from overflowing
always_ff @(posedge CLK) begin
    if (!rst_n) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        q_count <= '0;
    end else begin
        if (req_valid)
            wr_ptr <= wr_ptr + 1'b1;
        if (credit_return)
            rd_ptr <= rd_ptr + 1'b1;
        q_count <= q_count + (PTR_W+1)'(req_valid) - (PTR_W+1)'(credit_return);
    end
end

assign head_addr = q_addr[rd_ptr];

// Request being served
logic                    cur_write;
sdram_bank_t             cur_bank;
logic [`SDRAM_COL_W-1:0] cur_col;
sdram_data_t             cur_wdata;
sdram_tag_t              cur_tag;

always_ff @(posedge CLK) begin
    if (credit_return) begin
        cur_write <= q_write[rd_ptr];
        cur_bank  <= head_addr[`SDRAM_HOST_ADDR_W-1 -: `SDRAM_BANK_W];
        cur_col   <= head_addr[`SDRAM_COL_W-1:0];
        cur_wdata <= q_wdata[rd_ptr];
        cur_tag   <= q_tag[rd_ptr];
    end
end

// ************************************************************
// Refresh countdown
// ************************************************************
logic [CNT_W-1:0] ref_cnt;
logic             ref_due;

always_ff @(posedge CLK) begin
    if (!rst_n) begin
        ref_cnt <= CNT_W'(`SDRAM_T_REF);
        ref_due <= 1'b0;
    end else begin
        if (state == REFRESH)
            ref_due <= 1'b0;
        if (ref_cnt == '0) begin
            ref_cnt <= CNT_W'(`SDRAM_T_REF);
            ref_due <= 1'b1;     // Wins over the clear above
        end else begin
            ref_cnt <= ref_cnt - 1'b1;
        end
    end
end

// ************************************************************
// Command FSM
// ************************************************************
logic [CNT_W-1:0] wait_cnt;
logic             wait_done;
logic             init_ref_done;

assign wait_done = (wait_cnt == '0);

// A command goes out when wait_cnt is zero, then reloads it with gap-1
always_ff @(posedge CLK) begin
    if (!rst_n) begin
        state         <= INIT_WAIT;
        wait_cnt      <= CNT_W'(`SDRAM_T_INIT);
        init_ref_done <= 1'b0;
    end else begin
        if (!wait_done)
            wait_cnt <= wait_cnt - 1'b1;
        case (state)
            INIT_WAIT: if (wait_done) state <= INIT_PRE;
            INIT_PRE: begin
                wait_cnt <= CNT_W'(`SDRAM_T_RP - 1);
                state    <= INIT_REF;
            end
            INIT_REF: if (wait_done) begin
                wait_cnt      <= CNT_W'(`SDRAM_T_RC - 1);
                init_ref_done <= 1'b1;
                if (init_ref_done)
                    state <= INIT_MRS;   // Second refresh
            end
            INIT_MRS: if (wait_done) begin
                wait_cnt <= CNT_W'(`SDRAM_T_MRD - 1);
                state    <= IDLE;
            end
            IDLE: if (wait_done) begin
                if (ref_due)
                    state <= REFRESH;
                else if (q_count != '0)
                    state <= ACTIVATE;
            end
            ACTIVATE: begin
                wait_cnt <= CNT_W'(`SDRAM_T_RCD - 1);
                state    <= ACCESS;
            end
            ACCESS: if (wait_done) begin
                wait_cnt <= CNT_W'(RAS_GAP - 1);  // Holds PRE off until tRAS
                state    <= PRECHARGE;
            end
            PRECHARGE: if (wait_done) begin
                wait_cnt <= CNT_W'(`SDRAM_T_RP - 1);
                state    <= IDLE;
            end
            REFRESH: begin
                wait_cnt <= CNT_W'(`SDRAM_T_RC - 1);
                state    <= IDLE;
            end
            default: state <= IDLE;
        endcase
    end
end

always_comb begin
    op            = OP_NOP;
    bank          = cur_bank;
    row_addr      = sdram_row_t'(cur_col);   // A10 low, no auto precharge
    wdata         = cur_wdata;
    rd_issue      = 1'b0;
    credit_return = 1'b0;
    case (state)
        INIT_PRE: op = OP_PRE;
        INIT_REF: if (wait_done) op = OP_REF;
        INIT_MRS: if (wait_done) begin
            op       = OP_MRS;
            bank     = '0;
            row_addr = MODE_WORD;
        end
        ACTIVATE: begin
            op            = OP_ACT;
            bank          = head_addr[`SDRAM_HOST_ADDR_W-1 -: `SDRAM_BANK_W];
            row_addr      = head_addr[`SDRAM_COL_W +: `SDRAM_ROW_W];
            credit_return = 1'b1;    // Pop
        end
        ACCESS: if (wait_done) begin
            op       = cur_write ? OP_WRITE : OP_READ;
            rd_issue = !cur_write;
        end
        PRECHARGE: if (wait_done) op = OP_PRE;
        REFRESH:   op = OP_REF;
        default: ;
    endcase
end

assign rd_issue_tag = cur_tag;

endmodule

`default_nettype wire

// ==== hw/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

`include "sdram_cfg.svh"

    typedef logic [`SDRAM_DATA_W-1:0]      sdram_data_t;
    typedef logic [`SDRAM_TAG_W-1:0]       sdram_tag_t;
    typedef logic [`SDRAM_HOST_ADDR_W-1:0] host_addr_t;   // {bank, row, col}
    typedef logic [`SDRAM_ROW_W-1:0]       sdram_row_t;
    typedef logic [`SDRAM_BANK_W-1:0]      sdram_bank_t;

    // Commands from the scheduler to the pin stage
    typedef enum logic [2:0] {
        OP_NOP,
        OP_REF,
        OP_PRE,
        OP_ACT,
        OP_WRITE,
        OP_READ,
        OP_MRS
    } sdram_op_t;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRE,
        INIT_REF,
        INIT_MRS,
        IDLE,
        ACTIVATE,
        ACCESS,
        PRECHARGE,
        REFRESH
    } sched_state_t;

endpackage

`default_nettype wire

// ==== include/sdram_cfg.svh ====
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// Timing counts in CLK cycles
`define SDRAM_T_RCD   3
`define SDRAM_T_RP    3
`define SDRAM_T_RAS   6
`define SDRAM_T_RC    9
`define SDRAM_T_MRD   2
`define SDRAM_T_INIT  20     // Short power-up wait for simulation
`define SDRAM_T_REF   200

`define SDRAM_CAS     3
// Output register, CAS, capture register, alignment register
`define SDRAM_READ_LATENCY (`SDRAM_CAS + 3)

`define SDRAM_REQ_DEPTH 4    // Also the host's starting credits

// Widths
`define SDRAM_DATA_W      16
`define SDRAM_TAG_W       8
`define SDRAM_BANK_W      2
`define SDRAM_ROW_W       13
`define SDRAM_COL_W       9
`define SDRAM_HOST_ADDR_W (`SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W)

`endif
